// File: Makefile
# Verilator build of the hub tile testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f project.f --top-module tb_hub_tile -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_hub_tile

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/hub_cfg_slice.sv
`timescale 1ns/10ps

module hub_cfg_slice (
  input  logic                 clk_i
  , input  logic               rst_n_i
  , input  hub_pkg::mem_fwd_t  fwd_i
  , input  logic               fwd_v_i
  , output logic               fwd_ready_o
  , output hub_pkg::mem_rev_t  rev_o
  , output logic               rev_v_o
  , input  logic               rev_ready_i
  , input  hub_pkg::did_t      did_i
  , output hub_pkg::cfg_bus_t  cfg_o
);

  hub_pkg::local_addr_t local_addr;
  hub_pkg::word_t       rd_data;
  hub_pkg::mem_rev_t    rev_q;
  hub_pkg::core_id_t    core_id_q;
  logic                 freeze_q;
  logic                 rev_v_q;
  logic                 accept;

  assign local_addr  = fwd_i.addr;
  assign fwd_ready_o = ~rev_v_q | rev_ready_i;
  assign accept      = fwd_v_i & fwd_ready_o;

  always_comb begin
    case (local_addr.ofs)
      hub_pkg::CFG_FREEZE_OFS:  rd_data = hub_pkg::word_t'(freeze_q);
      hub_pkg::CFG_CORE_ID_OFS: rd_data = hub_pkg::word_t'(core_id_q);
      hub_pkg::CFG_DID_OFS:     rd_data = hub_pkg::word_t'(did_i);
      default:                  rd_data = '0;
    endcase
  end

  // Tile comes out of reset frozen
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      freeze_q  <= 1'b1;
      core_id_q <= '0;
    end else if (accept && fwd_i.wr) begin
      if (local_addr.ofs == hub_pkg::CFG_FREEZE_OFS) begin
        freeze_q <= fwd_i.data[0];
      end
      if (local_addr.ofs == hub_pkg::CFG_CORE_ID_OFS) begin
        core_id_q <= fwd_i.data[7:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rev_v_q <= 1'b0;
    end else if (accept) begin
      rev_v_q <= 1'b1;
    end else if (rev_ready_i) begin
      rev_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rev_q.wr   <= fwd_i.wr;
      rev_q.addr <= fwd_i.addr;
      rev_q.tag  <= fwd_i.tag;
      rev_q.data <= fwd_i.wr ? '0 : rd_data;
    end
  end

  assign rev_o           = rev_q;
  assign rev_v_o         = rev_v_q;
  assign cfg_o.freeze    = freeze_q;
  assign cfg_o.core_id   = core_id_q;

  // Stalled response must not change
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable(rev_o));

endmodule

// File: hdl/hub_clint_slice.sv
`timescale 1ns/10ps

module hub_clint_slice (
  input  logic                 clk_i
  , input  logic               rst_n_i
  , input  hub_pkg::mem_fwd_t  fwd_i
  , input  logic               fwd_v_i
  , output logic               fwd_ready_o
  , output hub_pkg::mem_rev_t  rev_o
  , output logic               rev_v_o
  , input  logic               rev_ready_i
  , input  logic               rt_tick_i
  , output logic               software_irq_o
  , output logic               timer_irq_o
);

  hub_pkg::local_addr_t local_addr;
  hub_pkg::word_t       mtime_q;
  hub_pkg::word_t       mtime_d;
  hub_pkg::word_t       mtimecmp_q;
  hub_pkg::word_t       mtimecmp_d;
  hub_pkg::word_t       rd_data;
  hub_pkg::mem_rev_t    rev_q;
  logic                 msip_q;
  logic                 msip_d;
  logic                 timer_irq_q;
  logic                 rev_v_q;
  logic                 accept;
  logic                 wr_en;

  assign local_addr  = fwd_i.addr;
  assign fwd_ready_o = ~rev_v_q | rev_ready_i;
  assign accept      = fwd_v_i & fwd_ready_o;
  assign wr_en       = accept & fwd_i.wr;

  // Next state, a write to mtime beats the tick
  always_comb begin
    msip_d     = msip_q;
    mtimecmp_d = mtimecmp_q;
    mtime_d    = rt_tick_i ? mtime_q + 1'b1 : mtime_q;
    if (wr_en) begin
      case (local_addr.ofs)
        hub_pkg::CLINT_MSIP_OFS:     msip_d     = fwd_i.data[0];
        hub_pkg::CLINT_MTIMECMP_OFS: mtimecmp_d = fwd_i.data;
        hub_pkg::CLINT_MTIME_OFS:    mtime_d    = fwd_i.data;
        default:                     msip_d     = msip_q;
      endcase
    end
  end

  always_comb begin
    case (local_addr.ofs)
      hub_pkg::CLINT_MSIP_OFS:     rd_data = hub_pkg::word_t'(msip_q);
      hub_pkg::CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
      hub_pkg::CLINT_MTIME_OFS:    rd_data = mtime_q;
      default:                     rd_data = '0;
    endcase
  end

  // Compare on next state so the irq lines up with the write response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      msip_q      <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_q <= 1'b0;
      rev_v_q     <= 1'b0;
    end else begin
      msip_q      <= msip_d;
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      timer_irq_q <= (mtime_d >= mtimecmp_d);
      if (accept) begin
        rev_v_q <= 1'b1;
      end else if (rev_ready_i) begin
        rev_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rev_q.wr   <= fwd_i.wr;
      rev_q.addr <= fwd_i.addr;
      rev_q.tag  <= fwd_i.tag;
      rev_q.data <= fwd_i.wr ? '0 : rd_data;
    end
  end

  assign rev_o          = rev_q;
  assign rev_v_o        = rev_v_q;
  assign software_irq_o = msip_q;
  assign timer_irq_o    = timer_irq_q;

endmodule

// File: hdl/hub_fwd_router.sv
`timescale 1ns/10ps

module hub_fwd_router (
  input  logic                                         clk_i
  , input  logic                                       rst_n_i
  , input  hub_pkg::mem_fwd_t                          mem_fwd_i
  , input  logic                                       mem_fwd_v_i
  , output logic                                       mem_fwd_ready_o
  , output hub_pkg::mem_fwd_t [hub_pkg::NUM_DEV-1:0]   dev_fwd_o
  , output logic [hub_pkg::NUM_DEV-1:0]                dev_fwd_v_o
  , input  logic [hub_pkg::NUM_DEV-1:0]                dev_fwd_ready_i
);

  hub_pkg::local_addr_t local_addr;
  hub_pkg::dst_t        dst;
  logic                 is_local;
  logic                 is_mem;
  logic                 is_cfg;
  logic                 is_clint;

  assign local_addr = mem_fwd_i.addr;
  assign is_local   = (mem_fwd_i.addr < hub_pkg::DRAM_BASE);
  assign is_mem     = ~is_local | (local_addr.dev == hub_pkg::CACHE_DEV);
  assign is_cfg     = local_addr.dev == hub_pkg::CFG_DEV;
  assign is_clint   = local_addr.dev == hub_pkg::CLINT_DEV;

  // Decode in priority order, memory wins
  always_comb begin
    if (is_mem) begin
      dst = hub_pkg::DST_MEM;
    end else if (is_cfg) begin
      dst = hub_pkg::DST_CFG;
    end else if (is_clint) begin
      dst = hub_pkg::DST_CLINT;
    end else begin
      dst = hub_pkg::DST_LOOP;
    end
  end

  always_comb begin
    for (int i = 0; i < hub_pkg::NUM_DEV; i++) begin
      dev_fwd_o[i]   = mem_fwd_i;
      dev_fwd_v_o[i] = mem_fwd_v_i & (dst == hub_pkg::dst_t'(i));
    end
  end

  assign mem_fwd_ready_o = dev_fwd_ready_i[dst];

  // A valid request reaches exactly one device
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(dev_fwd_v_o) && ((|dev_fwd_v_o) == mem_fwd_v_i));

endmodule

// File: hdl/hub_loopback.sv
`timescale 1ns/10ps

module hub_loopback (
  input  logic                 clk_i
  , input  logic               rst_n_i
  , input  hub_pkg::mem_fwd_t  fwd_i
  , input  logic               fwd_v_i
  , output logic               fwd_ready_o
  , output hub_pkg::mem_rev_t  rev_o
  , output logic               rev_v_o
  , input  logic               rev_ready_i
);

  hub_pkg::mem_rev_t rev_q;
  logic              rev_v_q;
  logic              accept;

  assign fwd_ready_o = ~rev_v_q | rev_ready_i;
  assign accept      = fwd_v_i & fwd_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rev_v_q <= 1'b0;
    end else if (accept) begin
      rev_v_q <= 1'b1;
    end else if (rev_ready_i) begin
      rev_v_q <= 1'b0;
    end
  end

  // Header echoed, write data dropped
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rev_q.wr   <= fwd_i.wr;
      rev_q.addr <= fwd_i.addr;
      rev_q.tag  <= fwd_i.tag;
      rev_q.data <= '0;
    end
  end

  assign rev_o   = rev_q;
  assign rev_v_o = rev_v_q;

endmodule

// File: hdl/hub_mem_slice.sv
`timescale 1ns/10ps

module hub_mem_slice (
  input  logic                 clk_i
  , input  logic               rst_n_i
  , input  hub_pkg::mem_fwd_t  fwd_i
  , input  logic               fwd_v_i
  , output logic               fwd_ready_o
  , output hub_pkg::mem_rev_t  rev_o
  , output logic               rev_v_o
  , input  logic               rev_ready_i
);

  hub_pkg::word_t                mem_q [hub_pkg::MEM_WORDS];
  hub_pkg::mem_rev_t             rev_q;
  logic [hub_pkg::MEM_IDX_W-1:0] idx;
  logic                          rev_v_q;
  logic                          accept;

  // Word index, byte offset dropped
  assign idx         = fwd_i.addr[hub_pkg::MEM_IDX_W+1:2];
  assign fwd_ready_o = ~rev_v_q | rev_ready_i;
  assign accept      = fwd_v_i & fwd_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept && fwd_i.wr) begin
      mem_q[idx] <= fwd_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rev_v_q <= 1'b0;
    end else if (accept) begin
      rev_v_q <= 1'b1;
    end else if (rev_ready_i) begin
      rev_v_q <= 1'b0;
    end
  end

  // Reads see the word from before this edge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rev_q.wr   <= fwd_i.wr;
      rev_q.addr <= fwd_i.addr;
      rev_q.tag  <= fwd_i.tag;
      rev_q.data <= fwd_i.wr ? '0 : mem_q[idx];
    end
  end

  assign rev_o   = rev_q;
  assign rev_v_o = rev_v_q;

endmodule

// File: hdl/hub_pkg.sv
package hub_pkg;

  typedef logic [19:0] paddr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  tag_t;
  typedef logic [2:0]  dev_id_t;
  typedef logic [1:0]  dst_t;
  typedef logic [15:0] dev_ofs_t;
  typedef logic [7:0]  core_id_t;
  typedef logic [7:0]  did_t;

  localparam int NUM_DEV   = 4;
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  localparam paddr_t DRAM_BASE = 20'h80000;

  localparam dev_id_t CFG_DEV   = 3'd1;
  localparam dev_id_t CLINT_DEV = 3'd2;
  localparam dev_id_t CACHE_DEV = 3'd3;

  // Device slots on the router and arbiter ports
  localparam dst_t DST_MEM   = 2'd0;
  localparam dst_t DST_CFG   = 2'd1;
  localparam dst_t DST_CLINT = 2'd2;
  localparam dst_t DST_LOOP  = 2'd3;

  localparam dev_ofs_t CFG_FREEZE_OFS  = 16'h0000;
  localparam dev_ofs_t CFG_CORE_ID_OFS = 16'h0004;
  localparam dev_ofs_t CFG_DID_OFS     = 16'h0008;

  localparam dev_ofs_t CLINT_MSIP_OFS     = 16'h0000;
  localparam dev_ofs_t CLINT_MTIMECMP_OFS = 16'h4000;
  localparam dev_ofs_t CLINT_MTIME_OFS    = 16'hbff8;

  // Split of an address below DRAM_BASE
  typedef struct packed {
    logic     dram;
    dev_id_t  dev;
    dev_ofs_t ofs;
  } local_addr_t;

  typedef struct packed {
    logic   wr;
    paddr_t addr;
    tag_t   tag;
    word_t  data;
  } mem_fwd_t;

  typedef struct packed {
    logic   wr;
    paddr_t addr;
    tag_t   tag;
    word_t  data;
  } mem_rev_t;

  typedef struct packed {
    logic     freeze;
    core_id_t core_id;
  } cfg_bus_t;

endpackage

// File: hdl/hub_rev_arbiter.sv
`timescale 1ns/10ps

module hub_rev_arbiter (
  input  logic                                         clk_i
  , input  logic                                       rst_n_i
  , input  hub_pkg::mem_rev_t [hub_pkg::NUM_DEV-1:0]   dev_rev_i
  , input  logic [hub_pkg::NUM_DEV-1:0]                dev_rev_v_i
  , output logic [hub_pkg::NUM_DEV-1:0]                dev_rev_ready_o
  , output hub_pkg::mem_rev_t                          mem_rev_o
  , output logic                                       mem_rev_v_o
  , input  logic                                       mem_rev_ready_i
);

  hub_pkg::dst_t              ptr_q;
  hub_pkg::dst_t              hold_sel_q;
  hub_pkg::dst_t              rr_sel;
  hub_pkg::dst_t              sel;
  logic [hub_pkg::NUM_DEV-1:0] grant;
  logic                       hold_q;
  logic                       rr_found;

  // Search starts one past the last winner
  always_comb begin
    hub_pkg::dst_t idx;
    rr_sel   = ptr_q;
    rr_found = 1'b0;
    for (int i = 1; i <= hub_pkg::NUM_DEV; i++) begin
      idx = ptr_q + hub_pkg::dst_t'(i);
      if (!rr_found && dev_rev_v_i[idx]) begin
        rr_sel   = idx;
        rr_found = 1'b1;
      end
    end
  end

  assign sel             = hold_q ? hold_sel_q : rr_sel;
  assign mem_rev_v_o     = dev_rev_v_i[sel];
  assign mem_rev_o       = dev_rev_i[sel];
  assign grant           = mem_rev_v_o ? (hub_pkg::NUM_DEV'(1) << sel) : '0;
  assign dev_rev_ready_o = grant & {hub_pkg::NUM_DEV{mem_rev_ready_i}};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q      <= hub_pkg::dst_t'(hub_pkg::NUM_DEV - 1);
      hold_q     <= 1'b0;
      hold_sel_q <= '0;
    end else begin
      hold_q     <= mem_rev_v_o & ~mem_rev_ready_i;
      hold_sel_q <= sel;
      if (mem_rev_v_o && mem_rev_ready_i) begin
        ptr_q <= sel;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rev_v_o |-> $onehot(grant) && ((grant & dev_rev_v_i) == grant));

endmodule

// File: hdl/hub_tile.sv
`timescale 1ns/10ps

module hub_tile (
  input  logic                 clk_i
  , input  logic               rst_n_i
  , input  hub_pkg::mem_fwd_t  mem_fwd_i
  , input  logic               mem_fwd_v_i
  , output logic               mem_fwd_ready_o
  , output hub_pkg::mem_rev_t  mem_rev_o
  , output logic               mem_rev_v_o
  , input  logic               mem_rev_ready_i
  , output hub_pkg::cfg_bus_t  cfg_o
  , input  hub_pkg::did_t      did_i
  , input  logic               rt_tick_i
  , output logic               software_irq_o
  , output logic               timer_irq_o
);

  // Slots are {loopback, CLINT, config, memory}
  hub_pkg::mem_fwd_t [hub_pkg::NUM_DEV-1:0] dev_fwd;
  logic [hub_pkg::NUM_DEV-1:0]              dev_fwd_v;
  logic [hub_pkg::NUM_DEV-1:0]              dev_fwd_ready;
  hub_pkg::mem_rev_t [hub_pkg::NUM_DEV-1:0] dev_rev;
  logic [hub_pkg::NUM_DEV-1:0]              dev_rev_v;
  logic [hub_pkg::NUM_DEV-1:0]              dev_rev_ready;

  hub_fwd_router fwd_router (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .mem_fwd_i(mem_fwd_i), .mem_fwd_v_i(mem_fwd_v_i), .mem_fwd_ready_o(mem_fwd_ready_o)
    , .dev_fwd_o(dev_fwd), .dev_fwd_v_o(dev_fwd_v), .dev_fwd_ready_i(dev_fwd_ready)
  );

  hub_mem_slice mem (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .fwd_i(dev_fwd[hub_pkg::DST_MEM]), .fwd_v_i(dev_fwd_v[hub_pkg::DST_MEM])
    , .fwd_ready_o(dev_fwd_ready[hub_pkg::DST_MEM])
    , .rev_o(dev_rev[hub_pkg::DST_MEM]), .rev_v_o(dev_rev_v[hub_pkg::DST_MEM])
    , .rev_ready_i(dev_rev_ready[hub_pkg::DST_MEM])
  );

  hub_cfg_slice cfg (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .fwd_i(dev_fwd[hub_pkg::DST_CFG]), .fwd_v_i(dev_fwd_v[hub_pkg::DST_CFG])
    , .fwd_ready_o(dev_fwd_ready[hub_pkg::DST_CFG])
    , .rev_o(dev_rev[hub_pkg::DST_CFG]), .rev_v_o(dev_rev_v[hub_pkg::DST_CFG])
    , .rev_ready_i(dev_rev_ready[hub_pkg::DST_CFG])
    , .did_i(did_i), .cfg_o(cfg_o)
  );

  hub_clint_slice clint (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .fwd_i(dev_fwd[hub_pkg::DST_CLINT]), .fwd_v_i(dev_fwd_v[hub_pkg::DST_CLINT])
    , .fwd_ready_o(dev_fwd_ready[hub_pkg::DST_CLINT])
    , .rev_o(dev_rev[hub_pkg::DST_CLINT]), .rev_v_o(dev_rev_v[hub_pkg::DST_CLINT])
    , .rev_ready_i(dev_rev_ready[hub_pkg::DST_CLINT])
    , .rt_tick_i(rt_tick_i)
    , .software_irq_o(software_irq_o), .timer_irq_o(timer_irq_o)
  );

  hub_loopback loopback (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .fwd_i(dev_fwd[hub_pkg::DST_LOOP]), .fwd_v_i(dev_fwd_v[hub_pkg::DST_LOOP])
    , .fwd_ready_o(dev_fwd_ready[hub_pkg::DST_LOOP])
    , .rev_o(dev_rev[hub_pkg::DST_LOOP]), .rev_v_o(dev_rev_v[hub_pkg::DST_LOOP])
    , .rev_ready_i(dev_rev_ready[hub_pkg::DST_LOOP])
  );

  hub_rev_arbiter rev_arbiter (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .dev_rev_i(dev_rev), .dev_rev_v_i(dev_rev_v), .dev_rev_ready_o(dev_rev_ready)
    , .mem_rev_o(mem_rev_o), .mem_rev_v_o(mem_rev_v_o), .mem_rev_ready_i(mem_rev_ready_i)
  );

endmodule

// File: project.f
hdl/hub_pkg.sv
hdl/hub_fwd_router.sv
hdl/hub_cfg_slice.sv
hdl/hub_clint_slice.sv
hdl/hub_loopback.sv
hdl/hub_mem_slice.sv
hdl/hub_rev_arbiter.sv
hdl/hub_tile.sv
testbench/tb_hub_tile.sv

// File: testbench/tb_hub_tile.sv
`timescale 1ns/10ps

module tb_hub_tile;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TAGS   = 16;
  localparam int FILL_N     = hub_pkg::MEM_WORDS;
  localparam int MEM_N      = 48;
  localparam int CFG_N      = 10;
  localparam int CLINT_N    = 14;
  localparam int LOOP_N     = 6;
  localparam int MIX_N      = 300;
  localparam int TICK_N     = 200;
  localparam int NUM_REQ    = FILL_N + 2 * MEM_N + CFG_N + CLINT_N + LOOP_N + MIX_N;

  logic              clk_i;
  logic              rst_n_i;
  hub_pkg::mem_fwd_t mem_fwd_i;
  logic              mem_fwd_v_i;
  logic              mem_fwd_ready_o;
  hub_pkg::mem_rev_t mem_rev_o;
  logic              mem_rev_v_o;
  logic              mem_rev_ready_i;
  hub_pkg::cfg_bus_t cfg_o;
  hub_pkg::did_t     did_i;
  logic              rt_tick_i;
  logic              software_irq_o;
  logic              timer_irq_o;

  // Reference model state starts at the hub reset values
  hub_pkg::word_t    mem_model [hub_pkg::MEM_WORDS];
  logic              freeze_model   = 1'b1;
  hub_pkg::core_id_t core_id_model  = '0;
  logic              msip_model     = 1'b0;
  hub_pkg::word_t    mtime_model    = '0;
  hub_pkg::word_t    mtimecmp_model = '1;

  hub_pkg::mem_rev_t exp_rev [NUM_TAGS];
  logic [NUM_TAGS-1:0] pending    = '0;
  hub_pkg::tag_t     next_tag     = '0;
  int                acc_count    = 0;
  int                rsp_count    = 0;
  int                seed         = 6;
  int                ready_seed   = 61;
  logic              rand_ready   = 1'b0;
  string             test_name    = "reset";

  hub_tile hub_tile_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .mem_fwd_i(mem_fwd_i), .mem_fwd_v_i(mem_fwd_v_i), .mem_fwd_ready_o(mem_fwd_ready_o)
    , .mem_rev_o(mem_rev_o), .mem_rev_v_o(mem_rev_v_o), .mem_rev_ready_i(mem_rev_ready_i)
    , .cfg_o(cfg_o), .did_i(did_i), .rt_tick_i(rt_tick_i)
    , .software_irq_o(software_irq_o), .timer_irq_o(timer_irq_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // About 30% stall cycles on the reverse stream
  always @(negedge clk_i) begin
    if (rand_ready) begin
      mem_rev_ready_i = ($unsigned($random(ready_seed)) % 10) >= 3;
    end else begin
      mem_rev_ready_i = 1'b1;
    end
  end

  function automatic hub_pkg::mem_rev_t ref_access(input hub_pkg::mem_fwd_t req);
    hub_pkg::mem_rev_t rsp;
    hub_pkg::dev_id_t  dev;
    hub_pkg::dev_ofs_t ofs;
    hub_pkg::word_t    rd;
    dev = req.addr[18:16];
    ofs = req.addr[15:0];
    rd  = '0;
    if (req.addr >= hub_pkg::DRAM_BASE || dev == hub_pkg::CACHE_DEV) begin
      rd = mem_model[req.addr[9:2]];
      if (req.wr) begin
        mem_model[req.addr[9:2]] = req.data;
      end
    end else if (dev == hub_pkg::CFG_DEV) begin
      if (ofs == hub_pkg::CFG_FREEZE_OFS) begin
        rd = hub_pkg::word_t'(freeze_model);
        if (req.wr) begin
          freeze_model = req.data[0];
        end
      end else if (ofs == hub_pkg::CFG_CORE_ID_OFS) begin
        rd = hub_pkg::word_t'(core_id_model);
        if (req.wr) begin
          core_id_model = req.data[7:0];
        end
      end else if (ofs == hub_pkg::CFG_DID_OFS) begin
        rd = hub_pkg::word_t'(did_i);
      end
    end else if (dev == hub_pkg::CLINT_DEV) begin
      if (ofs == hub_pkg::CLINT_MSIP_OFS) begin
        rd = hub_pkg::word_t'(msip_model);
        if (req.wr) begin
          msip_model = req.data[0];
        end
      end else if (ofs == hub_pkg::CLINT_MTIMECMP_OFS) begin
        rd = mtimecmp_model;
        if (req.wr) begin
          mtimecmp_model = req.data;
        end
      end else if (ofs == hub_pkg::CLINT_MTIME_OFS) begin
        rd = mtime_model;
        if (req.wr) begin
          mtime_model = req.data;
        end
      end
    end
    rsp.wr   = req.wr;
    rsp.addr = req.addr;
    rsp.tag  = req.tag;
    rsp.data = req.wr ? '0 : rd;
    return rsp;
  endfunction

  function automatic hub_pkg::cfg_bus_t cfg_model();
    hub_pkg::cfg_bus_t cfg;
    cfg.freeze  = freeze_model;
    cfg.core_id = core_id_model;
    return cfg;
  endfunction

  function automatic logic [1:0] irq_model();
    return {msip_model, mtime_model >= mtimecmp_model};
  endfunction

  function automatic hub_pkg::paddr_t dev_addr(input hub_pkg::dev_id_t dev,
                                               input hub_pkg::dev_ofs_t ofs);
    return {1'b0, dev, ofs};
  endfunction

  // Mixes the full DRAM range with the cache alias
  function automatic hub_pkg::paddr_t rand_mem_addr();
    logic [31:0] r;
    r = $random(seed);
    if (r[20]) begin
      return {1'b1, r[18:2], 2'b00};
    end
    return {1'b0, hub_pkg::CACHE_DEV, r[15:2], 2'b00};
  endfunction

  function automatic hub_pkg::word_t fill_word(input hub_pkg::paddr_t addr);
    return hub_pkg::word_t'(addr) * 32'h9e37_79b1 + 32'h1234_5678;
  endfunction

  task automatic report_fail(input string text);
    $display("%s", text);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_rev(input string name, input hub_pkg::mem_rev_t exp,
                           input hub_pkg::mem_rev_t act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_cfg(input string name, input hub_pkg::cfg_bus_t exp,
                           input hub_pkg::cfg_bus_t act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_irq(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Scoreboard runs the model in forward acceptance order
  always @(posedge clk_i) begin
    if (rst_n_i && mem_rev_v_o && mem_rev_ready_i) begin
      if ($isunknown(mem_rev_o.tag) || !pending[mem_rev_o.tag]) begin
        report_fail($sformatf("Response with tag %h has no request waiting for it",
                              mem_rev_o.tag));
      end else begin
        check_rev(test_name, exp_rev[mem_rev_o.tag], mem_rev_o);
        pending[mem_rev_o.tag] = 1'b0;
        rsp_count++;
      end
    end
    if (rst_n_i && mem_fwd_v_i && mem_fwd_ready_o) begin
      exp_rev[mem_fwd_i.tag] = ref_access(mem_fwd_i);
      pending[mem_fwd_i.tag] = 1'b1;
      acc_count++;
    end
  end

  task automatic send_req(input logic wr, input hub_pkg::paddr_t addr,
                          input hub_pkg::word_t data);
    hub_pkg::mem_fwd_t req;
    int                target;
    while (pending[next_tag]) begin
      @(negedge clk_i);
    end
    req.wr      = wr;
    req.addr    = addr;
    req.tag     = next_tag;
    req.data    = data;
    next_tag    = next_tag + 1'b1;
    target      = acc_count + 1;
    mem_fwd_i   = req;
    mem_fwd_v_i = 1'b1;
    @(negedge clk_i);
    while (acc_count != target) begin
      @(negedge clk_i);
    end
    mem_fwd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (rsp_count != acc_count) begin
      @(negedge clk_i);
    end
  endtask

  task automatic test_memory();
    hub_pkg::paddr_t addr;
    hub_pkg::paddr_t wr_addr [MEM_N];
    test_name = "memory";
    for (int i = 0; i < FILL_N; i++) begin
      addr = hub_pkg::DRAM_BASE + hub_pkg::paddr_t'(4 * i);
      send_req(1'b1, addr, fill_word(addr));
    end
    for (int i = 0; i < MEM_N; i++) begin
      wr_addr[i] = rand_mem_addr();
      send_req(1'b1, wr_addr[i], $random(seed));
    end
    for (int i = 0; i < MEM_N; i++) begin
      send_req(1'b0, wr_addr[i], '0);
    end
    wait_drain();
  endtask

  task automatic test_config();
    test_name = "config";
    check_cfg("config after reset", cfg_model(), cfg_o);
    send_req(1'b0, dev_addr(hub_pkg::CFG_DEV, hub_pkg::CFG_FREEZE_OFS), '0);
    send_req(1'b1, dev_addr(hub_pkg::CFG_DEV, hub_pkg::CFG_CORE_ID_OFS), 32'h0000_01a5);
    wait_drain();
    check_cfg("config core id write", cfg_model(), cfg_o);
    send_req(1'b1, dev_addr(hub_pkg::CFG_DEV, hub_pkg::CFG_FREEZE_OFS), 32'hffff_fffe);
    wait_drain();
    check_cfg("config freeze write", cfg_model(), cfg_o);
    send_req(1'b0, dev_addr(hub_pkg::CFG_DEV, hub_pkg::CFG_DID_OFS), '0);
    send_req(1'b0, dev_addr(hub_pkg::CFG_DEV, hub_pkg::CFG_CORE_ID_OFS), '0);
    send_req(1'b1, dev_addr(hub_pkg::CFG_DEV, 16'h000c), 32'hdead_beef);
    send_req(1'b0, dev_addr(hub_pkg::CFG_DEV, 16'h000c), '0);
    wait_drain();
  endtask

  task automatic test_clint_irq();
    test_name = "clint irq";
    check_irq("irq after reset", 2'b00, {software_irq_o, timer_irq_o});
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MSIP_OFS), 32'h1);
    wait_drain();
    check_irq("msip set", irq_model(), {software_irq_o, timer_irq_o});
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MSIP_OFS), 32'h0);
    wait_drain();
    check_irq("msip clear", irq_model(), {software_irq_o, timer_irq_o});
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIME_OFS), 32'd100);
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIMECMP_OFS), 32'd50);
    wait_drain();
    check_irq("mtimecmp below mtime", irq_model(), {software_irq_o, timer_irq_o});
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIMECMP_OFS), 32'd1000);
    wait_drain();
    check_irq("mtimecmp raised", irq_model(), {software_irq_o, timer_irq_o});
    send_req(1'b0, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MSIP_OFS), '0);
    send_req(1'b0, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIMECMP_OFS), '0);
    send_req(1'b0, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIME_OFS), '0);
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, 16'h0008), 32'h5555_aaaa);
    send_req(1'b0, dev_addr(hub_pkg::CLINT_DEV, 16'h0008), '0);
    wait_drain();
  endtask

  task automatic test_clint_time();
    logic [31:0] r;
    int          ticks;
    test_name = "clint time";
    ticks     = 0;
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIMECMP_OFS), 32'hffff_0000);
    send_req(1'b1, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIME_OFS), 32'h0000_1000);
    wait_drain();
    // Only the tick moves mtime on an idle bus
    repeat (TICK_N) begin
      @(negedge clk_i);
      r         = $random(seed);
      rt_tick_i = r[0];
      if (rt_tick_i) begin
        ticks++;
      end
    end
    @(negedge clk_i);
    rt_tick_i   = 1'b0;
    mtime_model = mtime_model + hub_pkg::word_t'(ticks);
    send_req(1'b0, dev_addr(hub_pkg::CLINT_DEV, hub_pkg::CLINT_MTIME_OFS), '0);
    wait_drain();
    check_irq("irq after ticks", irq_model(), {software_irq_o, timer_irq_o});
  endtask

  task automatic test_loopback();
    test_name = "loopback";
    send_req(1'b1, dev_addr(3'd4, 16'h0020), 32'h0bad_f00d);
    send_req(1'b0, dev_addr(3'd4, 16'h0020), '0);
    send_req(1'b1, dev_addr(3'd7, 16'h0000), 32'hcafe_0001);
    send_req(1'b0, dev_addr(3'd7, 16'h0000), '0);
    send_req(1'b1, dev_addr(3'd0, 16'h0040), 32'h7777_1234);
    send_req(1'b0, dev_addr(3'd0, 16'h0040), '0);
    wait_drain();
  endtask

  task automatic test_mixed();
    logic [31:0]       r;
    hub_pkg::paddr_t   addr;
    hub_pkg::dev_ofs_t ofs;
    test_name  = "mixed traffic";
    rand_ready = 1'b1;
    for (int i = 0; i < MIX_N; i++) begin
      r = $random(seed);
      case (r[9:8])
        2'd0:    ofs = hub_pkg::CLINT_MSIP_OFS;
        2'd1:    ofs = hub_pkg::CLINT_MTIMECMP_OFS;
        2'd2:    ofs = hub_pkg::CLINT_MTIME_OFS;
        default: ofs = 16'h0008;
      endcase
      case (r[1:0])
        2'd0:    addr = rand_mem_addr();
        2'd1:    addr = dev_addr(hub_pkg::CFG_DEV, hub_pkg::dev_ofs_t'({r[9:8], 2'b00}));
        2'd2:    addr = dev_addr(hub_pkg::CLINT_DEV, ofs);
        default: addr = dev_addr({1'b1, r[9:8]}, r[27:12]);
      endcase
      if (r[5:3] == 3'd0) begin
        @(negedge clk_i);
      end
      send_req(r[2], addr, $random(seed));
    end
    wait_drain();
    rand_ready = 1'b0;
    check_cfg("config after mixed traffic", cfg_model(), cfg_o);
    check_irq("irq after mixed traffic", irq_model(), {software_irq_o, timer_irq_o});
  endtask

  initial begin
    repeat (NUM_REQ * 40 + TICK_N + 2000) @(posedge clk_i);
    report_fail("Watchdog expired before the tests finished");
  end

  initial begin
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    mem_fwd_i       = '0;
    mem_fwd_v_i     = 1'b0;
    mem_rev_ready_i = 1'b1;
    did_i           = 8'h5a;
    rt_tick_i       = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    test_config();
    test_clint_irq();
    test_memory();
    test_clint_time();
    test_loopback();
    test_mixed();
    if (rsp_count == acc_count && pending == '0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      report_fail("Some responses never arrived on the reverse stream");
    end
  end

endmodule
